/* flist.f */
hdl/cop_pkg.sv
hdl/cop_sequencer.sv
hdl/cop_decoder.sv
hdl/cop_cpr_file.sv
hdl/cop_palu.sv
hdl/cop_gpr_writeback.sv
hdl/cop_top.sv
tests/cop_tb.sv

/* Makefile */
# Verilator build and run of the co-processor testbench

TOP := cop_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/cop_tb.sv */
/*
 * Testbench for the co-processor top level.
 * A CPU-side driver issues one instruction at a time with random back-pressure,
 * a reference model with a shadow CPR array predicts the writeback, and a
 * compare process checks the outputs at every retire. Run it through flist.f.
 */
`default_nettype none

module cop_tb;
    import cop_pkg::*;

    localparam int num_cprs = 16;
    localparam int n_insns  = 121;                            // Instructions issued below
    localparam longint watchdog_limit = (n_insns * 10 + 100) * 100;

    logic              g_clk;
    logic              g_resetn;
    logic              cpu_insn_req;
    logic [xlen-1:0]   cpu_insn_enc;
    logic [xlen-1:0]   cpu_rs1;
    logic              cpu_insn_ack;
    logic              cop_insn_ack;
    logic              cop_insn_rsp;
    logic              cop_wen;
    logic [4:0]        cop_waddr;
    logic [xlen-1:0]   cop_wdata;
    result_t           cop_result;

    logic [31:0]       shadow [num_cprs]; // Model copy of the CPRs
    logic              exp_wen;
    logic [4:0]        exp_waddr;
    logic [31:0]       exp_wdata;
    logic [2:0]        exp_result;
    int                n_issued;
    int                n_checked;

    cop_top #(.num_cprs(num_cprs)) uut (
        .g_clk, .g_resetn, .cpu_insn_req, .cop_insn_ack, .cpu_insn_enc, .cpu_rs1,
        .cop_wen, .cop_waddr, .cop_wdata, .cop_result, .cop_insn_rsp, .cpu_insn_ack
    );

    always #50 g_clk = ~g_clk; // Period 100

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            report_error($sformatf("MISMATCH at time %0t: %s expected %h, actual %h",
                                   $time, name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge g_clk);
        #5; // Drive point after the edge
    endtask

    function automatic logic [31:0] encode_reg(input op_t op, input logic [4:0] dst,
            input logic [4:0] src1, input logic [3:0] src2, input pw_t pw);
        cop_insn_u w;
        w           = '0;
        w.rv.opcode = cop_opcode;
        w.rv.dst    = dst;
        w.rv.op     = op;
        w.rv.src1   = src1;
        w.rv.src2   = src2;
        w.rv.pw     = pw;
        return w;
    endfunction

    function automatic logic [31:0] encode_imm(input logic [4:0] dst, input logic [15:0] imm,
                                               input logic hsel);
        cop_insn_u w;
        w.iv.opcode = cop_opcode;
        w.iv.dst    = dst;
        w.iv.op     = op_ins_imm;
        w.iv.imm16  = imm;
        w.iv.hsel   = hsel;
        return w;
    endfunction

    // Predicts the writeback and updates the shadow CPRs
    function automatic void cop_model(input logic [31:0] enc, input logic [31:0] rs1,
            output logic e_wen, output logic [4:0] e_waddr, output logic [31:0] e_wdata,
            output logic [2:0] e_result);
        logic [2:0]  op;
        logic [4:0]  dst;
        logic [4:0]  src1;
        logic [3:0]  src2;
        logic [1:0]  pw;
        logic        bad;
        logic [31:0] old;
        logic [31:0] mask;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] s;
        logic [31:0] r;
        int          lw;
        op   = enc[14:12];
        dst  = enc[11:7];
        src1 = enc[19:15];
        src2 = enc[23:20];
        pw   = enc[25:24];
        bad  = enc[6:0] != 7'h2b || op > 3'd4;
        bad  = bad || ((op == op_padd || op == op_psub) && pw == 2'd3);
        bad  = bad || (op != op_ins_imm && enc[31:26] != 6'd0);     // Pad in register view
        bad  = bad || (op != op_mv_c2g && dst >= 5'(num_cprs));      // dst names a CPR
        bad  = bad || (op >= op_mv_c2g && op <= op_psub && src1 >= 5'(num_cprs));
        e_wen    = !bad && op == op_mv_c2g;
        e_waddr  = dst;
        e_wdata  = shadow[src1[3:0]];
        e_result = bad ? 3'd1 : 3'd0;
        if (!bad) begin
            old = shadow[dst[3:0]];
            case (op)
                op_mv_g2c: shadow[dst[3:0]] = rs1;
                op_padd, op_psub: begin
                    lw   = 32 >> pw;                     // Lane width in bits
                    mask = 32'hffff_ffff >> (32 - lw);
                    r    = '0;
                    for (int i = 0; i < 32 / lw; i++) begin
                        x = (shadow[src1[3:0]] >> (i * lw)) & mask;
                        y = (shadow[src2] >> (i * lw)) & mask;
                        s = op == op_padd ? x + y : x - y;
                        r = r | ((s & mask) << (i * lw)); // Wrap inside the lane
                    end
                    shadow[dst[3:0]] = r;
                end
                op_ins_imm: shadow[dst[3:0]] = enc[31] ? {enc[30:15], old[15:0]}
                                                       : {old[31:16], enc[30:15]};
                default: ;
            endcase
        end
    endfunction

    // One instruction from request to retire, with 0 to 3 stalled cycles
    task automatic issue(input logic [31:0] enc, input logic [31:0] rs1);
        int          hold;
        logic        snap_wen;
        logic [4:0]  snap_waddr;
        logic [31:0] snap_wdata;
        logic [2:0]  snap_result;
        cop_model(enc, rs1, exp_wen, exp_waddr, exp_wdata, exp_result);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        while (!cop_insn_ack) next_cycle();
        next_cycle();                      // Accept edge
        n_issued++;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = $urandom();         // DUT must work from its captured copy
        cpu_rs1      = $urandom();
        check_eq("cop_insn_rsp", 32'd1, 32'(cop_insn_rsp));
        check_eq("cop_insn_ack", 32'd0, 32'(cop_insn_ack));
        hold        = $urandom_range(3, 0);
        snap_wen    = cop_wen;
        snap_waddr  = cop_waddr;
        snap_wdata  = cop_wdata;
        snap_result = cop_result;
        repeat (hold) begin
            next_cycle();                  // Stalled, everything must hold
            check_eq("cop_insn_rsp", 32'd1, 32'(cop_insn_rsp));
            check_eq("cop_insn_ack", 32'd0, 32'(cop_insn_ack));
            check_eq("cop_wen", 32'(snap_wen), 32'(cop_wen));
            check_eq("cop_waddr", 32'(snap_waddr), 32'(cop_waddr));
            check_eq("cop_wdata", snap_wdata, cop_wdata);
            check_eq("cop_result", 32'(snap_result), 32'(cop_result));
        end
        cpu_insn_ack = 1'b1;
        next_cycle();                      // Retire edge
        cpu_insn_ack = 1'b0;
        check_eq("cop_insn_rsp", 32'd0, 32'(cop_insn_rsp));
    endtask

    task automatic read_cpr(input logic [3:0] idx);
        issue(encode_reg(op_mv_c2g, 5'($urandom_range(31, 0)), {1'b0, idx}, 4'd0, pw_32),
              $urandom());
    endtask

    // Compare at the negative edge before each retire edge
    always @(negedge g_clk) begin
        if (g_resetn && cop_insn_rsp && cpu_insn_ack) begin
            check_eq("cop_result", 32'(exp_result), 32'(cop_result));
            check_eq("cop_wen", 32'(exp_wen), 32'(cop_wen));
            if (exp_wen) begin
                check_eq("cop_waddr", 32'(exp_waddr), 32'(cop_waddr));
                check_eq("cop_wdata", exp_wdata, cop_wdata);
            end
            n_checked++;
        end
    end

    initial begin
        #(watchdog_limit);
        report_error($sformatf("Timeout: run did not finish within %0d time units",
                               watchdog_limit));
    end

    initial begin
        logic [3:0] crd;
        logic [3:0] c1;
        logic [3:0] c2;
        void'($urandom(6));
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        n_issued     = 0;
        n_checked    = 0;
        for (int i = 0; i < num_cprs; i++) shadow[i] = '0;
        repeat (4) @(posedge g_clk);
        #5;
        check_eq("cop_insn_ack", 32'd0, 32'(cop_insn_ack)); // Quiet while in reset
        check_eq("cop_insn_rsp", 32'd0, 32'(cop_insn_rsp));
        g_resetn = 1'b1;
        for (int i = 0; i < 2 && !cop_insn_ack; i++) next_cycle();
        if (!cop_insn_ack) report_error("cop_insn_ack did not rise within 2 cycles of reset");

        // Fill every CPR from a GPR, then read each back
        for (int i = 0; i < num_cprs; i++) begin
            issue(encode_reg(op_mv_g2c, 5'(i), 5'd0, 4'd0, pw_32), $urandom());
        end
        for (int i = 0; i < num_cprs; i++) read_cpr(4'(i));

        // Packed add and subtract at each lane width
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 8; k++) begin
                crd = 4'($urandom_range(15, 0));
                c1  = 4'($urandom_range(15, 0));
                c2  = 4'($urandom_range(15, 0));
                issue(encode_reg(k[0] ? op_psub : op_padd, {1'b0, crd}, {1'b0, c1}, c2, 2'(p)),
                      $urandom());
                read_cpr(crd);
            end
        end

        // Low then high halfword insert
        for (int k = 0; k < 4; k++) begin
            crd = 4'($urandom_range(15, 0));
            issue(encode_imm({1'b0, crd}, 16'($urandom()), 1'b0), $urandom());
            read_cpr(crd);
            issue(encode_imm({1'b0, crd}, 16'($urandom()), 1'b1), $urandom());
            read_cpr(crd);
        end

        // Illegal encodings, then confirm no CPR changed
        issue(encode_reg(op_mv_g2c, 5'd3, 5'd0, 4'd0, pw_32) ^ 32'h1, $urandom()); // Opcode 2A
        for (int k = 5; k < 8; k++) issue(encode_reg(3'(k), 5'd2, 5'd1, 4'd1, pw_32), $urandom());
        issue(encode_reg(op_padd, 5'd4, 5'd1, 4'd2, 2'd3), $urandom());
        issue(encode_reg(op_mv_g2c, 5'd5, 5'd0, 4'd0, pw_32) | 32'h0400_0000, $urandom());
        issue(encode_reg(op_mv_g2c, 5'd17, 5'd0, 4'd0, pw_32), $urandom()); // Aliases CPR 1
        issue(encode_reg(op_mv_c2g, 5'd3, 5'd20, 4'd0, pw_32), $urandom());
        issue(encode_imm(5'd30, 16'($urandom()), 1'b0), $urandom());
        for (int i = 0; i < num_cprs; i++) read_cpr(4'(i));

        if (n_checked == n_issued) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_error($sformatf("%0d instructions issued but %0d retirements checked",
                                   n_issued, n_checked));
        end
    end

endmodule

`default_nettype wire

/* hdl/cop_top.sv */
/*
 * Co-processor top level.
 * Connects the sequencer, decoder, register file, packed ALU and writeback.
 * num_cprs sets the register file depth and the decoder's index check.
 */
`default_nettype none

module cop_top #(
    parameter int num_cprs = 16
) (
    input  logic                           g_clk,
    input  logic                           g_resetn,
    input  logic                           cpu_insn_req,
    output logic                           cop_insn_ack,
    input  logic [cop_pkg::xlen-1:0]       cpu_insn_enc,
    input  logic [cop_pkg::xlen-1:0]       cpu_rs1,
    output logic                           cop_wen,
    output logic [cop_pkg::gpr_addr_w-1:0] cop_waddr,
    output logic [cop_pkg::xlen-1:0]       cop_wdata,
    output cop_pkg::result_t               cop_result,
    output logic                           cop_insn_rsp,
    input  logic                           cpu_insn_ack
);
    import cop_pkg::*;

    logic                  insn_accept;
    cop_insn_u             insn_word;
    logic [xlen-1:0]       gpr_rs1;
    logic                  id_exception;
    op_t                   id_op;
    pw_t                   id_pw;
    logic [cpr_addr_w-1:0] id_crd;
    logic [cpr_addr_w-1:0] id_crs1;
    logic [cpr_addr_w-1:0] id_crs2;
    logic [gpr_addr_w-1:0] id_rd;
    logic [15:0]           id_imm16;
    logic                  id_hsel;
    logic                  id_gpr_wen;
    logic [xlen-1:0]       crs1_rdata;
    logic [xlen-1:0]       crs2_rdata;
    logic [xlen-1:0]       crs3_rdata;
    logic [3:0]            cpr_wen;
    logic [xlen-1:0]       cpr_wdata;
    logic [xlen-1:0]       palu_result;

    cop_sequencer u_sequencer (
        .g_clk, .g_resetn, .cpu_insn_req, .cpu_insn_enc, .cpu_rs1, .cpu_insn_ack,
        .cop_insn_ack, .cop_insn_rsp, .insn_accept, .insn_word, .gpr_rs1
    );

    cop_decoder #(.num_cprs(num_cprs)) u_decoder (
        .insn_word, .id_exception, .id_op, .id_pw, .id_crd, .id_crs1, .id_crs2,
        .id_rd, .id_imm16, .id_hsel, .id_gpr_wen
    );

    // Port 3 reads the destination for the halfword insert
    cop_cpr_file #(.num_cprs(num_cprs)) u_cpr_file (
        .g_clk, .g_resetn,
        .crs1_addr(id_crs1), .crs2_addr(id_crs2), .crs3_addr(id_crd),
        .crd_addr(id_crd), .crd_wen(cpr_wen), .crd_wdata(cpr_wdata),
        .crs1_rdata, .crs2_rdata, .crs3_rdata
    );

    cop_palu u_palu (
        .insn_accept, .id_exception, .id_op, .id_pw, .id_imm16, .id_hsel, .gpr_rs1,
        .crs1_rdata, .crs2_rdata, .crs3_rdata, .cpr_wen, .cpr_wdata, .palu_result
    );

    cop_gpr_writeback u_gpr_writeback (
        .g_clk, .g_resetn, .insn_accept, .id_exception, .id_gpr_wen, .id_rd,
        .palu_result, .cop_wen, .cop_waddr, .cop_wdata, .cop_result
    );

endmodule

`default_nettype wire

/* hdl/cop_gpr_writeback.sv */
/*
 * Registered writeback toward the CPU.
 * Latches the GPR write and the result code at accept and holds them
 * until the next accepted instruction.
 */
`default_nettype none

module cop_gpr_writeback (
    input  logic                           g_clk,
    input  logic                           g_resetn,
    input  logic                           insn_accept,
    input  logic                           id_exception,
    input  logic                           id_gpr_wen,
    input  logic [cop_pkg::gpr_addr_w-1:0] id_rd,
    input  logic [cop_pkg::xlen-1:0]       palu_result,
    output logic                           cop_wen,
    output logic [cop_pkg::gpr_addr_w-1:0] cop_waddr,
    output logic [cop_pkg::xlen-1:0]       cop_wdata,
    output cop_pkg::result_t               cop_result
);
    import cop_pkg::*;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_wen    <= 1'b0;
            cop_result <= res_success;
        end else if (insn_accept) begin
            cop_wen    <= id_gpr_wen && !id_exception; // No write on bad insn
            cop_result <= id_exception ? res_bad_ins : res_success;
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            cop_waddr <= id_rd;
            cop_wdata <= palu_result;
        end
    end

endmodule

`default_nettype wire

/* hdl/cop_palu.sv */
/*
 * Packed arithmetic unit.
 * Computes moves, lane-wise add and subtract at 32, 16 and 8 bits, and the
 * halfword immediate insert, all in one cycle. The CPR write is issued only
 * for a legal instruction in its accept cycle.
 */
`default_nettype none

module cop_palu (
    input  logic                     insn_accept,
    input  logic                     id_exception,
    input  cop_pkg::op_t             id_op,
    input  cop_pkg::pw_t             id_pw,
    input  logic [15:0]              id_imm16,
    input  logic                     id_hsel,
    input  logic [cop_pkg::xlen-1:0] gpr_rs1,
    input  logic [cop_pkg::xlen-1:0] crs1_rdata,
    input  logic [cop_pkg::xlen-1:0] crs2_rdata,
    input  logic [cop_pkg::xlen-1:0] crs3_rdata, // Old destination value
    output logic [3:0]               cpr_wen,
    output logic [cop_pkg::xlen-1:0] cpr_wdata,
    output logic [cop_pkg::xlen-1:0] palu_result
);
    import cop_pkg::*;

    logic            is_sub;
    logic            cpr_write;
    logic [xlen-1:0] lane_res;  // Packed add/sub result
    logic [xlen-1:0] ins_res;   // Halfword insert result

    assign is_sub = id_op == op_psub;

    // Carries never cross a lane boundary
    always_comb begin
        lane_res = '0;
        case (id_pw)
            pw_16: begin
                for (int i = 0; i < 2; i++) begin
                    lane_res[i*16 +: 16] = is_sub ?
                        crs1_rdata[i*16 +: 16] - crs2_rdata[i*16 +: 16] :
                        crs1_rdata[i*16 +: 16] + crs2_rdata[i*16 +: 16];
                end
            end
            pw_8: begin
                for (int i = 0; i < 4; i++) begin
                    lane_res[i*8 +: 8] = is_sub ?
                        crs1_rdata[i*8 +: 8] - crs2_rdata[i*8 +: 8] :
                        crs1_rdata[i*8 +: 8] + crs2_rdata[i*8 +: 8];
                end
            end
            default: begin
                lane_res = is_sub ? crs1_rdata - crs2_rdata : crs1_rdata + crs2_rdata;
            end
        endcase
    end

    assign ins_res = id_hsel ? {id_imm16, crs3_rdata[15:0]}
                             : {crs3_rdata[31:16], id_imm16};

    always_comb begin
        case (id_op)
            op_mv_g2c:        palu_result = gpr_rs1;
            op_mv_c2g:        palu_result = crs1_rdata; // GPR bound only
            op_padd, op_psub: palu_result = lane_res;
            op_ins_imm:       palu_result = ins_res;
            default:          palu_result = '0;
        endcase
    end

    assign cpr_write = insn_accept && !id_exception && id_op != op_mv_c2g;
    assign cpr_wen   = {4{cpr_write}};
    assign cpr_wdata = palu_result;

endmodule

`default_nettype wire

/* hdl/cop_cpr_file.sv */
/*
 * Co-processor register file.
 * num_cprs words, cleared at reset, with three combinational read ports
 * and one write port that updates whole bytes under per-byte enables.
 */
`default_nettype none

module cop_cpr_file #(
    parameter int num_cprs = 16
) (
    input  logic                           g_clk,
    input  logic                           g_resetn,
    input  logic [cop_pkg::cpr_addr_w-1:0] crs1_addr,
    input  logic [cop_pkg::cpr_addr_w-1:0] crs2_addr,
    input  logic [cop_pkg::cpr_addr_w-1:0] crs3_addr,
    input  logic [cop_pkg::cpr_addr_w-1:0] crd_addr,
    input  logic [3:0]                     crd_wen,   // One enable per byte
    input  logic [cop_pkg::xlen-1:0]       crd_wdata,
    output logic [cop_pkg::xlen-1:0]       crs1_rdata,
    output logic [cop_pkg::xlen-1:0]       crs2_rdata,
    output logic [cop_pkg::xlen-1:0]       crs3_rdata
);
    import cop_pkg::*;

    logic [xlen-1:0] cprs [num_cprs];

    // Indices past the top word read as zero
    assign crs1_rdata = 32'(crs1_addr) < num_cprs ? cprs[crs1_addr] : '0;
    assign crs2_rdata = 32'(crs2_addr) < num_cprs ? cprs[crs2_addr] : '0;
    assign crs3_rdata = 32'(crs3_addr) < num_cprs ? cprs[crs3_addr] : '0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < num_cprs; i++) begin
                cprs[i] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (crd_wen[b]) begin
                    cprs[crd_addr][b*8 +: 8] <= crd_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cop_decoder.sv */
/*
 * Instruction decoder.
 * Picks the register or immediate view of the word by its op field,
 * extracts register indices and the immediate, and flags any illegal
 * encoding, including CPR indices at or beyond num_cprs.
 */
`default_nettype none

module cop_decoder #(
    parameter int num_cprs = 16
) (
    input  cop_pkg::cop_insn_u             insn_word,
    output logic                           id_exception,
    output cop_pkg::op_t                   id_op,
    output cop_pkg::pw_t                   id_pw,
    output logic [cop_pkg::cpr_addr_w-1:0] id_crd,
    output logic [cop_pkg::cpr_addr_w-1:0] id_crs1,
    output logic [cop_pkg::cpr_addr_w-1:0] id_crs2,
    output logic [cop_pkg::gpr_addr_w-1:0] id_rd,
    output logic [15:0]                    id_imm16,
    output logic                           id_hsel,
    output logic                           id_gpr_wen
);
    import cop_pkg::*;

    logic is_imm;   // Immediate view in use
    logic is_arith; // padd or psub
    logic use_crd;
    logic use_crs1;
    logic bad_op;
    logic bad_pw;
    logic bad_pad;
    logic bad_idx;

    // True for an index the register file does not hold
    function automatic logic cpr_bad(input logic [4:0] idx);
        return idx >= 5'(num_cprs);
    endfunction

    assign id_op   = insn_word.rv.op;
    assign id_pw   = insn_word.rv.pw;
    assign id_rd   = insn_word.rv.dst;
    assign id_crd  = insn_word.rv.dst[cpr_addr_w-1:0];
    assign id_crs1 = insn_word.rv.src1[cpr_addr_w-1:0];
    assign id_crs2 = insn_word.rv.src2;

    assign is_imm   = id_op == op_ins_imm;
    assign is_arith = id_op == op_padd || id_op == op_psub;
    assign use_crd  = id_op == op_mv_g2c || is_arith || is_imm;
    assign use_crs1 = id_op == op_mv_c2g || is_arith;

    assign id_imm16 = is_imm ? insn_word.iv.imm16 : 16'h0000; // Other ops carry no immediate
    assign id_hsel  = is_imm && insn_word.iv.hsel;

    assign bad_op  = id_op > op_ins_imm;                  // Codes 5 to 7
    assign bad_pw  = is_arith && id_pw == 2'd3;
    assign bad_pad = !is_imm && insn_word.rv.pad != 6'd0; // Pad only exists in register view
    assign bad_idx = (use_crd && cpr_bad(insn_word.rv.dst))
                  || (use_crs1 && cpr_bad(insn_word.rv.src1))
                  || (is_arith && cpr_bad({1'b0, insn_word.rv.src2}));

    assign id_exception = insn_word.rv.opcode != cop_opcode
                       || bad_op || bad_pw || bad_pad || bad_idx;

    assign id_gpr_wen = id_op == op_mv_c2g; // Only move to GPR writes back

endmodule

`default_nettype wire

/* hdl/cop_sequencer.sv */
/*
 * Accept and response control toward the CPU.
 * Runs the request/acknowledge handshake through idle, waiting and finished,
 * and captures the instruction word and rs1 operand at accept. In the accept
 * cycle both pass straight through; afterwards the captured copies are shown.
 */
`default_nettype none

module cop_sequencer (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    cpu_insn_req,  // CPU offers an instruction
    input  logic [cop_pkg::xlen-1:0] cpu_insn_enc,
    input  logic [cop_pkg::xlen-1:0] cpu_rs1,
    input  logic                    cpu_insn_ack,  // CPU takes the response
    output logic                    cop_insn_ack,
    output logic                    cop_insn_rsp,
    output logic                    insn_accept,
    output cop_pkg::cop_insn_u      insn_word,
    output logic [cop_pkg::xlen-1:0] gpr_rs1
);
    import cop_pkg::*;

    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_waiting  = 2'd1;
    localparam logic [1:0] st_finished = 2'd2;

    logic [1:0]      state;
    logic [1:0]      n_state;
    logic            n_ack;
    logic            n_rsp;
    logic            insn_retire;
    logic [xlen-1:0] r_insn_enc; // Held instruction word
    logic [xlen-1:0] r_rs1;      // Held operand

    assign insn_accept = cpu_insn_req && cop_insn_ack;
    assign insn_retire = cop_insn_rsp && cpu_insn_ack;

    assign insn_word = insn_accept ? cpu_insn_enc : r_insn_enc; // Pass through on accept
    assign gpr_rs1   = insn_accept ? cpu_rs1      : r_rs1;

    always_comb begin
        n_state = st_idle;
        n_ack   = 1'b0;
        n_rsp   = 1'b0;
        case (state)
            st_idle: begin
                n_state = st_waiting; // Offer ack straight after reset
                n_ack   = 1'b1;
            end
            st_waiting: begin
                if (insn_accept) begin
                    n_state = st_finished; // Units finish in the accept cycle
                    n_rsp   = 1'b1;
                end else begin
                    n_state = st_waiting;
                    n_ack   = 1'b1;
                end
            end
            st_finished: begin
                if (insn_retire) begin
                    n_state = st_waiting;
                    n_ack   = 1'b1;
                end else begin
                    n_state = st_finished; // Hold rsp under back-pressure
                    n_rsp   = 1'b1;
                end
            end
            default: n_state = st_idle;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= st_idle;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
        end else begin
            state        <= n_state;
            cop_insn_ack <= n_ack;
            cop_insn_rsp <= n_rsp;
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            r_insn_enc <= cpu_insn_enc;
            r_rs1      <= cpu_rs1;
        end
    end

endmodule

`default_nettype wire

/* hdl/cop_pkg.sv */
/*
 * Shared definitions for the crypto co-processor.
 * Holds the data and address widths, the operation, pack-width and result
 * codes, and the instruction word with its register and immediate views.
 * Modules take it in with a wildcard import inside the module body.
 */
`default_nettype none

package cop_pkg;

    localparam int xlen       = 32; // Data word width
    localparam int gpr_addr_w = 5;  // CPU register index
    localparam int cpr_addr_w = 4;  // Co-processor register index

    localparam logic [6:0] cop_opcode = 7'h2b; // Only major opcode accepted

    typedef logic [2:0] op_t;
    localparam op_t op_mv_g2c  = 3'd0; // GPR to CPR move
    localparam op_t op_mv_c2g  = 3'd1; // CPR to GPR move
    localparam op_t op_padd    = 3'd2; // Packed add
    localparam op_t op_psub    = 3'd3; // Packed subtract
    localparam op_t op_ins_imm = 3'd4; // Halfword insert

    typedef logic [1:0] pw_t;
    localparam pw_t pw_32 = 2'd0; // One 32-bit lane
    localparam pw_t pw_16 = 2'd1; // Two 16-bit lanes
    localparam pw_t pw_8  = 2'd2; // Four 8-bit lanes

    typedef logic [2:0] result_t;
    localparam result_t res_success = 3'd0;
    localparam result_t res_bad_ins = 3'd1;

    // Register view, used by moves and packed arithmetic
    typedef struct packed {
        logic [5:0] pad;    // Must be zero
        pw_t        pw;
        logic [3:0] src2;
        logic [4:0] src1;
        op_t        op;
        logic [4:0] dst;
        logic [6:0] opcode;
    } cop_insn_reg_t;

    // Immediate view, used by the halfword insert
    typedef struct packed {
        logic        hsel;  // 1 selects upper halfword
        logic [15:0] imm16;
        op_t         op;
        logic [4:0]  dst;
        logic [6:0]  opcode;
    } cop_insn_imm_t;

    typedef union packed {
        cop_insn_reg_t rv;
        cop_insn_imm_t iv;
    } cop_insn_u;

endpackage

`default_nettype wire
